// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the memory fabric testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module legMemSystemTb \
  -f sim.f \
  -o legMemSystemSim

./obj_dir/legMemSystemSim | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

// ==== sim.f ====
verilog/legMemPkg.sv
verilog/busArbiter.sv
verilog/ahbMemory.sv
verilog/cp15Regs.sv
verilog/legMemSystem.sv
testbench/legMemSystem_checker.sv
testbench/legMemSystemTb.sv

// ==== testbench/legMemSystemTb.sv ====
// Memory fabric testbench
`timescale 1ns/10ps
`default_nettype none

module legMemSystemTb;

  // Edges from request on an idle bus to the ready edge
  localparam int busLatency = 2 + legMemPkg::memWaitStates;
  localparam int maxWait = busLatency + 4;
  // Cycle budget for about 36 bus accesses, 30 CP15 accesses and reset
  localparam int testCycles = 10 + 36 * (busLatency + 3) + 30 * 3;

  logic                clk;
  logic                rst;
  legMemPkg::busReq_t  fetchReq;
  legMemPkg::busReq_t  dataReq;
  legMemPkg::busReq_t  walkReq;
  logic                fetchReady;
  logic                dataReady;
  logic                walkReady;
  logic [31:0]         rdata;
  logic                irq;
  logic                fiq;
  legMemPkg::cp15Req_t cp15Req;
  logic [31:0]         cp15Rd;
  logic                icacheEnable;
  logic                dcacheEnable;
  logic                mmuEnable;
  logic                highVectors;
  logic [17:0]         tbase;
  logic                invalidateI;
  logic                invalidateD;
  logic                tlbFlushI;
  logic                tlbFlushD;

  logic [15:0] lfsrState;
  int          errorCount;
  int          checkCount;

  legMemSystem legMemSystem_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #(testCycles * 20);
    $display("Watchdog expired after %0d ns, the tests did not finish", testCycles * 20);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Fibonacci LFSR on taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] randBits(input int count);
    logic [31:0] bits;
    logic        feedback;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], feedback};
      bits = {bits[30:0], feedback};
    end
    return bits;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checkCount++;
    assert (got === expected)
    else
    begin
      errorCount++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  // Port 0 is fetch, 1 is data and 2 is walk
  task automatic driveReq(input int port, input legMemPkg::busReq_t req);
    case (port)
      0: fetchReq = req;
      1: dataReq = req;
      default: walkReq = req;
    endcase
  endtask

  function automatic logic portReady(input int port);
    case (port)
      0: return fetchReady;
      1: return dataReady;
      default: return walkReady;
    endcase
  endfunction

  // One transfer held until its ready has been sampled
  task automatic busAccess(input int port, input logic write, input logic [2:0] size,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] readData);
    legMemPkg::busReq_t req;
    int                 waited;
    req.request = 1'b1;
    req.write = write;
    req.size = size;
    req.addr = addr;
    req.wdata = wdata;
    readData = '0;
    waited = 0;
    @(negedge clk);
    driveReq(port, req);
    @(negedge clk);
    while (!portReady(port) && waited < maxWait)
    begin
      waited++;
      @(negedge clk);
    end
    if (portReady(port))
    begin
      readData = rdata;
      @(negedge clk);
    end
    else
    begin
      errorCount++;
      $display("Error: port %0d saw no ready within %0d cycles", port, maxWait);
    end
    driveReq(port, '0);
  endtask

  task automatic cp15Write(input logic [3:0] addr, input logic [3:0] crm,
                           input logic [2:0] op2, input logic [31:0] wdata);
    legMemPkg::cp15Req_t req;
    req.en = 1'b1;
    req.wrEn = 1'b1;
    req.addr = addr;
    req.crm = crm;
    req.op2 = op2;
    req.wdata = wdata;
    @(negedge clk);
    cp15Req = req;
    // Returns in the cycle after the write edge
    @(negedge clk);
    cp15Req = '0;
  endtask

  task automatic cp15Read(input logic [3:0] addr, output logic [31:0] readData);
    legMemPkg::cp15Req_t req;
    req = '0;
    req.en = 1'b1;
    req.addr = addr;
    @(negedge clk);
    cp15Req = req;
    @(negedge clk);
    readData = cp15Rd;
    cp15Req = '0;
  endtask

  task automatic resetValues();
    checkValue("readies", 32'({walkReady, dataReady, fetchReady}), 32'd0);
    checkValue("irq and fiq", 32'({fiq, irq}), 32'd0);
    checkValue("pulses", 32'({invalidateI, invalidateD, tlbFlushI, tlbFlushD}), 32'd0);
    checkValue("enables", 32'({icacheEnable, dcacheEnable, mmuEnable, highVectors}), 32'd0);
    checkValue("tbase", 32'(tbase), 32'd0);
  endtask

  task automatic wordReadback();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] got;
    for (int port = 0; port < 3; port++)
    begin
      r = randBits(8);
      addr = {22'b0, r[7:0], 2'b00};
      data = randBits(32);
      busAccess(port, 1'b1, legMemPkg::hsizeWord, addr, data, got);
      // Read back through the next port
      busAccess((port + 1) % 3, 1'b0, legMemPkg::hsizeWord, addr, '0, got);
      checkValue("rdata", got, data);
    end
  endtask

  task automatic sizedWriteLanes();
    logic [31:0] r;
    logic [31:0] base;
    logic [31:0] wdata;
    logic [31:0] expected;
    logic [31:0] got;
    r = randBits(8);
    base = {22'b0, r[7:0], 2'b00};
    expected = randBits(32);
    busAccess(1, 1'b1, legMemPkg::hsizeWord, base, expected, got);
    for (int lane = 0; lane < 4; lane++)
    begin
      r = randBits(8);
      // Untargeted lanes carry the complement
      wdata = ~{4{r[7:0]}};
      wdata[8*lane +: 8] = r[7:0];
      busAccess(1, 1'b1, legMemPkg::hsizeByte, base + 32'(lane), wdata, got);
      expected[8*lane +: 8] = r[7:0];
      busAccess(2, 1'b0, legMemPkg::hsizeWord, base, '0, got);
      checkValue("rdata after byte write", got, expected);
    end
    for (int half = 0; half < 2; half++)
    begin
      r = randBits(16);
      wdata = ~{2{r[15:0]}};
      wdata[16*half +: 16] = r[15:0];
      busAccess(0, 1'b1, legMemPkg::hsizeHalf, base + 32'(2 * half), wdata, got);
      expected[16*half +: 16] = r[15:0];
      busAccess(2, 1'b0, legMemPkg::hsizeWord, base, '0, got);
      checkValue("rdata after halfword write", got, expected);
    end
  endtask

  task automatic arbitrationOrder();
    legMemPkg::busReq_t req;
    int                 readyAt [3];
    logic [2:0]         pending;
    logic [2:0]         seen;
    int                 cycle;
    req = '0;
    req.request = 1'b1;
    req.size = legMemPkg::hsizeWord;
    readyAt = '{-1, -1, -1};
    pending = 3'b111;
    seen = 3'b000;
    cycle = 0;
    @(negedge clk);
    for (int p = 0; p < 3; p++)
    begin
      req.addr = 32'(4 * p);
      driveReq(p, req);
    end
    while (pending != 3'b000 && cycle < 3 * busLatency + 6)
    begin
      @(negedge clk);
      cycle++;
      // Drop requests that passed their ready edge
      for (int p = 0; p < 3; p++)
      begin
        if (seen[p])
          driveReq(p, '0);
      end
      seen = 3'b000;
      for (int p = 0; p < 3; p++)
      begin
        if (pending[p] && portReady(p))
        begin
          readyAt[p] = cycle;
          pending[p] = 1'b0;
          seen[p] = 1'b1;
        end
      end
    end
    @(negedge clk);
    fetchReq = '0;
    dataReq = '0;
    walkReq = '0;
    if (pending != 3'b000)
    begin
      errorCount++;
      $display("Error: not every requester got its ready during arbitration");
    end
    // Order is walk then data then fetch with one re-arbitration cycle between
    checkValue("walkReady cycle", 32'(readyAt[2]), 32'(busLatency));
    checkValue("dataReady cycle", 32'(readyAt[1]), 32'(2 * busLatency + 1));
    checkValue("fetchReady cycle", 32'(readyAt[0]), 32'(3 * busLatency + 2));
  endtask

  task automatic interruptLevels();
    logic [31:0] got;
    logic [31:0] levels [4];
    levels = '{32'd1, 32'd2, 32'd3, 32'd0};
    for (int i = 0; i < 4; i++)
    begin
      busAccess(1, 1'b1, legMemPkg::hsizeWord, legMemPkg::intCtrlAddr, levels[i], got);
      checkValue("irq", 32'(irq), 32'(levels[i][0]));
      checkValue("fiq", 32'(fiq), 32'(levels[i][1]));
      busAccess(0, 1'b0, legMemPkg::hsizeWord, legMemPkg::intCtrlAddr, '0, got);
      checkValue("rdata at intCtrlAddr", got, levels[i]);
    end
    // Just past the RAM and then far outside it
    busAccess(1, 1'b1, legMemPkg::hsizeWord, 32'h0000_0400, 32'hFFFF_FFFF, got);
    busAccess(2, 1'b0, legMemPkg::hsizeWord, 32'h0000_0400, '0, got);
    checkValue("rdata unmapped", got, 32'd0);
    busAccess(2, 1'b0, legMemPkg::hsizeWord, 32'h8000_0000, '0, got);
    checkValue("rdata unmapped", got, 32'd0);
  endtask

  task automatic cp15RegisterAccess();
    logic [31:0] value;
    logic [31:0] got;
    value = randBits(32);
    for (int pass = 0; pass < 2; pass++)
    begin
      cp15Write(legMemPkg::cp15RegControl, 4'd0, 3'd0, value);
      cp15Read(legMemPkg::cp15RegControl, got);
      checkValue("cp15Rd control", got, value);
      checkValue("icacheEnable", 32'(icacheEnable), 32'(value[12]));
      checkValue("dcacheEnable", 32'(dcacheEnable), 32'(value[2]));
      checkValue("mmuEnable", 32'(mmuEnable), 32'(value[0]));
      checkValue("highVectors", 32'(highVectors), 32'(value[13]));
      // Every bit flips for the second pass
      value = ~value;
    end
    value = randBits(32);
    cp15Write(legMemPkg::cp15RegTbase, 4'd0, 3'd0, value);
    cp15Read(legMemPkg::cp15RegTbase, got);
    checkValue("cp15Rd tbase", got, value);
    checkValue("tbase", 32'(tbase), 32'(value[31:14]));
    cp15Read(4'd0, got);
    checkValue("cp15Rd id", got, legMemPkg::cp15IdValue);
    cp15Read(4'd5, got);
    checkValue("cp15Rd unused", got, 32'd0);
  endtask

  // Pulses last only the cycle after the write edge
  task automatic expectPulses(input logic [3:0] expected);
    checkValue("pulses", 32'({invalidateI, invalidateD, tlbFlushI, tlbFlushD}),
               32'(expected));
    @(negedge clk);
    checkValue("pulses next cycle",
               32'({invalidateI, invalidateD, tlbFlushI, tlbFlushD}), 32'd0);
  endtask

  task automatic maintenancePulses();
    logic [3:0] regs [2];
    logic [3:0] crms [3];
    logic [1:0] sides [3];
    logic [3:0] expected;
    regs = '{legMemPkg::cp15RegCache, legMemPkg::cp15RegTlb};
    crms = '{legMemPkg::crmSideI, legMemPkg::crmSideD, legMemPkg::crmSideBoth};
    // Expected I side and D side for each CRm code
    sides = '{2'b10, 2'b01, 2'b11};
    for (int r = 0; r < 2; r++)
    begin
      for (int c = 0; c < 3; c++)
      begin
        if (r == 0)
          expected = {sides[c], 2'b00};
        else
          expected = {2'b00, sides[c]};
        cp15Write(regs[r], crms[c], 3'd0, 32'd0);
        expectPulses(expected);
      end
      // Nonzero op2 is not a maintenance op
      cp15Write(regs[r], legMemPkg::crmSideBoth, 3'd2, 32'd0);
      expectPulses(4'b0000);
    end
  endtask

  initial
  begin
    rst = 1'b1;
    fetchReq = '0;
    dataReq = '0;
    walkReq = '0;
    cp15Req = '0;
    lfsrState = 16'd29;
    errorCount = 0;
    checkCount = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    resetValues();
    wordReadback();
    sizedWriteLanes();
    arbitrationOrder();
    interruptLevels();
    cp15RegisterAccess();
    maintenancePulses();
    $display("Checks run %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/legMemSystem_checker.sv ====
// Bus arbiter grant checks
`timescale 1ns/10ps
`default_nettype none

module legMemSystem_checker (
  input logic               clk,
  input logic               rst,
  input logic [2:0]         grant,
  input logic               memReady,
  input legMemPkg::busReq_t fetchReq,
  input legMemPkg::busReq_t dataReq,
  input legMemPkg::busReq_t walkReq,
  input logic               fetchReady,
  input logic               dataReady,
  input logic               walkReady
);

  // One owner at most
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("Arbiter grant %b is not one-hot", grant);

  // Owner keeps the bus until its transfer completes
  grantHeld: assert property (@(posedge clk) disable iff (rst)
    (grant != 3'b000 && !memReady) |=> (grant == $past(grant)))
    else $error("Arbiter grant changed before memReady");

  readyOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({walkReady, dataReady, fetchReady}))
    else $error("More than one ready is high");

  readyHasRequest: assert property (@(posedge clk) disable iff (rst)
    (!walkReady || walkReq.request) && (!dataReady || dataReq.request) &&
    (!fetchReady || fetchReq.request))
    else $error("Ready is high for a requester that is not requesting");

endmodule

bind busArbiter legMemSystem_checker legMemSystem_checker_i (
  .clk        (clk),
  .rst        (rst),
  .grant      (grant),
  .memReady   (memReady),
  .fetchReq   (fetchReq),
  .dataReq    (dataReq),
  .walkReq    (walkReq),
  .fetchReady (fetchReady),
  .dataReady  (dataReady),
  .walkReady  (walkReady)
);

`default_nettype wire

// ==== verilog/ahbMemory.sv ====
// Single-beat bus memory
`timescale 1ns/10ps
`default_nettype none

module ahbMemory (
  input  logic                clk,
  input  logic                rst,
  input  legMemPkg::busReq_t  memReq,
  output logic                memReady,
  output logic [31:0]         rdata,
  output logic                irq,
  output logic                fiq
);

  logic [31:0] ram [legMemPkg::memWords];

  logic                             busy;
  logic [legMemPkg::memWaitBits-1:0] waitCount;
  logic [7:0]                       wordIdx;
  logic                             inRam;
  logic                             isIntCtrl;
  logic [3:0]                       byteMask;

  assign wordIdx = memReq.addr[9:2];
  assign inRam = (memReq.addr < 32'(legMemPkg::memWords * 4));
  assign isIntCtrl = (memReq.addr == legMemPkg::intCtrlAddr);

  // Request seen on an idle bus, wait states, then one ready cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      waitCount <= '0;
      memReady <= 1'b0;
    end
    else if (memReady)
    begin
      memReady <= 1'b0;
    end
    else if (busy)
    begin
      if (waitCount == legMemPkg::memWaitBits'(1))
      begin
        busy <= 1'b0;
        memReady <= 1'b1;
      end
      waitCount <= waitCount - 1'b1;
    end
    else if (memReq.request)
    begin
      busy <= 1'b1;
      waitCount <= legMemPkg::memWaitBits'(legMemPkg::memWaitStates);
    end
  end

  // Byte lanes, write data is expected on its own lanes as on AHB
  always_comb
  begin
    case (memReq.size)
      legMemPkg::hsizeByte: byteMask = 4'b0001 << memReq.addr[1:0];
      legMemPkg::hsizeHalf: byteMask = memReq.addr[1] ? 4'b1100 : 4'b0011;
      legMemPkg::hsizeWord: byteMask = 4'b1111;
      default:              byteMask = 4'b0000;
    endcase
  end

  // Write lands at the closing edge of the ready cycle
  always_ff @(posedge clk)
  begin
    if (memReady && memReq.write && inRam)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        if (byteMask[lane])
          ram[wordIdx][8*lane +: 8] <= memReq.wdata[8*lane +: 8];
      end
    end
  end

  // Interrupt levels
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      irq <= 1'b0;
      fiq <= 1'b0;
    end
    else if (memReady && memReq.write && isIntCtrl)
    begin
      irq <= memReq.wdata[0];
      fiq <= memReq.wdata[1];
    end
  end

  // Whole word read; unmapped space reads zero
  always_comb
  begin
    if (inRam)
      rdata = ram[wordIdx];
    else if (isIntCtrl)
      rdata = {30'b0, fiq, irq};
    else
      rdata = '0;
  end

endmodule

`default_nettype wire

// ==== verilog/busArbiter.sv ====
// Three-way bus arbiter
`timescale 1ns/10ps
`default_nettype none

module busArbiter (
  input  logic                clk,
  input  logic                rst,
  input  legMemPkg::busReq_t  fetchReq,
  input  legMemPkg::busReq_t  dataReq,
  input  legMemPkg::busReq_t  walkReq,
  input  logic                memReady,
  output legMemPkg::busReq_t  memReq,
  output logic                fetchReady,
  output logic                dataReady,
  output logic                walkReady
);

  // One-hot owner: bit 2 walk, bit 1 data, bit 0 fetch
  logic [2:0] grant;
  logic       idle;

  assign idle = (grant == 3'b000);

  // Fixed priority when idle, released on the ready edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= 3'b000;
    end
    else if (idle)
    begin
      if (walkReq.request)
      begin
        grant <= 3'b100;
      end
      else if (dataReq.request)
      begin
        grant <= 3'b010;
      end
      else if (fetchReq.request)
      begin
        grant <= 3'b001;
      end
    end
    else if (memReady)
    begin
      grant <= 3'b000;
    end
  end

  // Owner's request onto the memory side
  always_comb
  begin
    case (grant)
      3'b100:
      begin
        memReq = walkReq;
      end
      3'b010:
      begin
        memReq = dataReq;
      end
      3'b001:
      begin
        memReq = fetchReq;
      end
      default:
      begin
        // Nothing granted, request stays low
        memReq = '0;
      end
    endcase
  end

  // Ready goes back to the owner only
  assign walkReady = memReady & grant[2];
  assign dataReady = memReady & grant[1];
  assign fetchReady = memReady & grant[0];

endmodule

`default_nettype wire

// ==== verilog/cp15Regs.sv ====
// Coprocessor 15 registers
`timescale 1ns/10ps
`default_nettype none

module cp15Regs (
  input  logic                clk,
  input  logic                rst,
  input  legMemPkg::cp15Req_t cp15Req,
  output logic [31:0]         cp15Rd,
  output logic                icacheEnable,
  output logic                dcacheEnable,
  output logic                mmuEnable,
  output logic                highVectors,
  output logic [17:0]         tbase,
  output logic                invalidateI,
  output logic                invalidateD,
  output logic                tlbFlushI,
  output logic                tlbFlushD
);

  legMemPkg::cp15Control_u control;
  logic [31:0]             transBase;

  logic regWrite;
  logic maintWrite;
  logic sideI;
  logic sideD;
  logic nextInvI;
  logic nextInvD;
  logic nextFlushI;
  logic nextFlushD;

  assign regWrite = cp15Req.en & cp15Req.wrEn;
  // Maintenance ops only count with op2 of zero
  assign maintWrite = regWrite & (cp15Req.op2 == 3'd0);

  assign sideI = (cp15Req.crm == legMemPkg::crmSideI) ||
                 (cp15Req.crm == legMemPkg::crmSideBoth);
  assign sideD = (cp15Req.crm == legMemPkg::crmSideD) ||
                 (cp15Req.crm == legMemPkg::crmSideBoth);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      control.raw <= '0;
      transBase <= '0;
    end
    else if (regWrite)
    begin
      if (cp15Req.addr == legMemPkg::cp15RegControl)
        control.raw <= cp15Req.wdata;
      if (cp15Req.addr == legMemPkg::cp15RegTbase)
        transBase <= cp15Req.wdata;
    end
  end

  // Maintenance decode, register 7 for caches and 8 for TLBs
  always_comb
  begin
    nextInvI = 1'b0;
    nextInvD = 1'b0;
    nextFlushI = 1'b0;
    nextFlushD = 1'b0;
    if (maintWrite)
    begin
      if (cp15Req.addr == legMemPkg::cp15RegCache)
      begin
        nextInvI = sideI;
        nextInvD = sideD;
      end
      else if (cp15Req.addr == legMemPkg::cp15RegTlb)
      begin
        nextFlushI = sideI;
        nextFlushD = sideD;
      end
    end
  end

  // Pulses show up in the cycle after the write edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      invalidateI <= 1'b0;
      invalidateD <= 1'b0;
      tlbFlushI <= 1'b0;
      tlbFlushD <= 1'b0;
    end
    else
    begin
      invalidateI <= nextInvI;
      invalidateD <= nextInvD;
      tlbFlushI <= nextFlushI;
      tlbFlushD <= nextFlushD;
    end
  end

  // Read port
  always_comb
  begin
    cp15Rd = '0;
    if (cp15Req.en)
    begin
      case (cp15Req.addr)
        4'd0:                      cp15Rd = legMemPkg::cp15IdValue;
        legMemPkg::cp15RegControl: cp15Rd = control.raw;
        legMemPkg::cp15RegTbase:   cp15Rd = transBase;
        default:                   cp15Rd = '0;
      endcase
    end
  end

  assign icacheEnable = control.fields.icacheEnable;
  assign dcacheEnable = control.fields.dcacheEnable;
  assign mmuEnable = control.fields.mmuEnable;
  assign highVectors = control.fields.highVectors;
  // Table base is 16 KB aligned
  assign tbase = transBase[31:14];

endmodule

`default_nettype wire

// ==== verilog/legMemPkg.sv ====
// Memory fabric definitions
`default_nettype none

package legMemPkg;

  // RAM size in 32-bit words, byte addresses 0x000 to 0x3FF
  localparam int memWords = 256;

  // Idle cycles between grant and ready, at least one
  localparam int memWaitStates = 1;
  localparam int memWaitBits = $clog2(memWaitStates + 1);

  // Interrupt register, bit 0 is irq and bit 1 is fiq
  localparam logic [31:0] intCtrlAddr = 32'hFFFF_0000;

  // Transfer size codes
  localparam logic [2:0] hsizeByte = 3'd0;
  localparam logic [2:0] hsizeHalf = 3'd1;
  localparam logic [2:0] hsizeWord = 3'd2;

  // CP15 main ID value ("LEG0" in ASCII)
  localparam logic [31:0] cp15IdValue = 32'h4C45_4730;

  // CP15 register numbers
  localparam logic [3:0] cp15RegControl = 4'd1;
  localparam logic [3:0] cp15RegTbase = 4'd2;
  localparam logic [3:0] cp15RegCache = 4'd7;
  localparam logic [3:0] cp15RegTlb = 4'd8;

  // CRm side select for cache and TLB maintenance
  localparam logic [3:0] crmSideI = 4'd5;
  localparam logic [3:0] crmSideD = 4'd6;
  localparam logic [3:0] crmSideBoth = 4'd7;

  // One requester's view of the bus
  typedef struct packed {
    logic        request;
    logic        write;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
  } busReq_t;

  // Coprocessor access from the core
  typedef struct packed {
    logic        en;
    logic        wrEn;
    logic [3:0]  addr;
    logic [3:0]  crm;
    logic [2:0]  op2;
    logic [31:0] wdata;
  } cp15Req_t;

  // Control register bit layout, MSB first
  typedef struct packed {
    logic [17:0] reservedHigh;
    logic        highVectors;
    logic        icacheEnable;
    logic [8:0]  reservedMid;
    logic        dcacheEnable;
    logic        reservedLow;
    logic        mmuEnable;
  } cp15ControlFields_t;

  // Control register, read raw over the coprocessor port or by field
  typedef union packed {
    logic [31:0]        raw;
    cp15ControlFields_t fields;
  } cp15Control_u;

endpackage

`default_nettype wire

// ==== verilog/legMemSystem.sv ====
// Memory fabric top level
`timescale 1ns/10ps
`default_nettype none

module legMemSystem (
  input  logic                clk,
  input  logic                rst,
  input  legMemPkg::busReq_t  fetchReq,
  input  legMemPkg::busReq_t  dataReq,
  input  legMemPkg::busReq_t  walkReq,
  output logic                fetchReady,
  output logic                dataReady,
  output logic                walkReady,
  output logic [31:0]         rdata,
  output logic                irq,
  output logic                fiq,
  input  legMemPkg::cp15Req_t cp15Req,
  output logic [31:0]         cp15Rd,
  output logic                icacheEnable,
  output logic                dcacheEnable,
  output logic                mmuEnable,
  output logic                highVectors,
  output logic [17:0]         tbase,
  output logic                invalidateI,
  output logic                invalidateD,
  output logic                tlbFlushI,
  output logic                tlbFlushD
);

  // Granted request and its ready
  legMemPkg::busReq_t memReq;
  logic               memReady;

  busArbiter busArbiter_i (
    .clk        (clk),
    .rst        (rst),
    .fetchReq   (fetchReq),
    .dataReq    (dataReq),
    .walkReq    (walkReq),
    .memReady   (memReady),
    .memReq     (memReq),
    .fetchReady (fetchReady),
    .dataReady  (dataReady),
    .walkReady  (walkReady)
  );

  ahbMemory ahbMemory_i (
    .clk      (clk),
    .rst      (rst),
    .memReq   (memReq),
    .memReady (memReady),
    .rdata    (rdata),
    .irq      (irq),
    .fiq      (fiq)
  );

  cp15Regs cp15Regs_i (
    .clk          (clk),
    .rst          (rst),
    .cp15Req      (cp15Req),
    .cp15Rd       (cp15Rd),
    .icacheEnable (icacheEnable),
    .dcacheEnable (dcacheEnable),
    .mmuEnable    (mmuEnable),
    .highVectors  (highVectors),
    .tbase        (tbase),
    .invalidateI  (invalidateI),
    .invalidateD  (invalidateD),
    .tlbFlushI    (tlbFlushI),
    .tlbFlushD    (tlbFlushD)
  );

endmodule

`default_nettype wire
